// File: streamer_top.f
mem_pkg.sv
streamer_pkg.sv
streamer_ctrl.sv
stream_source.sv
stream_sink.sv
mem_ldst_arbiter.sv
streamer_top.sv
streamer_checker.sv
tb_clock_gen.sv
streamer_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module streamer_tb \
		-f streamer_top.f -o streamer_sim
	./obj_dir/streamer_sim +verilator+error+limit+1000 | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: streamer_tb.sv
// Streamer testbench with word memory model, random stream and grant stimulus,
// stream reference model and per-test report
`timescale 1ns/1ps

module streamer_tb;

  localparam int unsigned NUM_SOURCES = streamer_pkg::NUM_SOURCES;
  localparam int unsigned DATA_W      = mem_pkg::DATA_W;
  localparam int unsigned ADDR_W      = mem_pkg::ADDR_W;
  localparam int unsigned CHAN_W      = $clog2(NUM_SOURCES + 1);
  localparam int unsigned MEM_WORDS   = 1 << ADDR_W;
  localparam int unsigned NUM_JOBS    = 2;
  localparam int unsigned MAX_LEN     = 40;
  localparam int unsigned PERIOD_NS   = 40;
  // Watchdog budget per transferred word plus setup slack
  localparam int unsigned WORD_CYCLES   = 16;
  localparam int unsigned MARGIN_CYCLES = 200;

  logic                               clk;
  logic                               rst_n;
  logic                               cfg_we;
  logic [CHAN_W-1:0]                  cfg_chan;
  streamer_pkg::cfg_field_e           cfg_field;
  logic [ADDR_W-1:0]                  cfg_wdata;
  logic                               start;
  logic [NUM_SOURCES-1:0]             src_ready  = '0;
  logic                               z_valid    = 1'b0;
  logic [DATA_W-1:0]                  z_data     = '0;
  logic                               mem_gnt    = 1'b0;
  logic                               mem_rvalid = 1'b0;
  logic [DATA_W-1:0]                  mem_rdata  = '0;
  logic                               busy;
  logic                               done;
  logic [NUM_SOURCES-1:0]             src_valid;
  logic [NUM_SOURCES-1:0][DATA_W-1:0] src_data;
  logic                               z_ready;
  logic                               mem_req;
  logic                               mem_we;
  logic [ADDR_W-1:0]                  mem_addr;
  logic [DATA_W-1:0]                  mem_wdata;

  integer      seed = 89356;
  int unsigned err_cnt = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned limit_ns = 0;

  // Memory model and its expected final image
  logic [DATA_W-1:0] mem     [MEM_WORDS];
  logic [DATA_W-1:0] ref_mem [MEM_WORDS];

  // Job table with the store channel at index NUM_SOURCES
  logic [ADDR_W-1:0] base_tab [NUM_JOBS][NUM_SOURCES+1];
  int unsigned       len_tab  [NUM_JOBS][NUM_SOURCES+1];
  logic [DATA_W-1:0] z_words  [NUM_JOBS][MAX_LEN];

  int unsigned cur_job = 0;
  int unsigned rd_cnt [NUM_SOURCES];
  int unsigned wr_cnt = 0;
  int unsigned z_idx = 0;
  int unsigned done_cnt = 0;
  bit          job_active = 1'b0;

  tb_clock_gen #(
    .PERIOD_NS    ( PERIOD_NS ),
    .RESET_CYCLES ( 5         )
  ) i_clock_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  streamer_top #(
    .NUM_SOURCES ( NUM_SOURCES ),
    .DATA_W      ( DATA_W      ),
    .ADDR_W      ( ADDR_W      ),
    .FIFO_DEPTH  ( streamer_pkg::FIFO_DEPTH )
  ) UUT (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .cfg_we_i     ( cfg_we     ),
    .cfg_chan_i   ( cfg_chan   ),
    .cfg_field_i  ( cfg_field  ),
    .cfg_wdata_i  ( cfg_wdata  ),
    .start_i      ( start      ),
    .src_ready_i  ( src_ready  ),
    .z_valid_i    ( z_valid    ),
    .z_data_i     ( z_data     ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  ),
    .busy_o       ( busy       ),
    .done_o       ( done       ),
    .src_valid_o  ( src_valid  ),
    .src_data_o   ( src_data   ),
    .z_ready_o    ( z_ready    ),
    .mem_req_o    ( mem_req    ),
    .mem_we_o     ( mem_we     ),
    .mem_addr_o   ( mem_addr   ),
    .mem_wdata_o  ( mem_wdata  )
  );

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      err_cnt++;
    end
  endtask

  // Random bases in disjoint 4K windows with one window per channel
  task automatic build_jobs();
    for (int j = 0; j < NUM_JOBS; j++) begin
      for (int k = 0; k <= NUM_SOURCES; k++) begin
        base_tab[j][k] = ADDR_W'((k << 12) | rand_below(1024));
        len_tab[j][k]  = 1 + rand_below(MAX_LEN);
      end
      for (int i = 0; i < MAX_LEN; i++) z_words[j][i] = $random(seed);
    end
    // Second job has one load channel with nothing to do
    len_tab[1][rand_below(NUM_SOURCES)] = 0;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]     = $random(seed);
      ref_mem[a] = mem[a];
    end
    for (int j = 0; j < NUM_JOBS; j++) begin
      for (int i = 0; i < len_tab[j][NUM_SOURCES]; i++) begin
        ref_mem[ADDR_W'(base_tab[j][NUM_SOURCES] + i)] = z_words[j][i];
      end
    end
  endtask

  task automatic write_cfg(input int unsigned chan, input streamer_pkg::cfg_field_e field,
                           input logic [ADDR_W-1:0] data);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_chan  <= CHAN_W'(chan);
    cfg_field <= field;
    cfg_wdata <= data;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic run_job(input int unsigned j);
    logic [ADDR_W-1:0] a;
    cur_job <= j;
    for (int k = 0; k <= NUM_SOURCES; k++) begin
      write_cfg(k, streamer_pkg::CFG_BASE, base_tab[j][k]);
      write_cfg(k, streamer_pkg::CFG_LEN, ADDR_W'(len_tab[j][k]));
    end
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    // Watchdog bounds this wait
    do @(posedge clk); while (!done);
    repeat (4) @(posedge clk);
    check_true(done_cnt == 1, $sformatf("done_o pulsed %0d times in job %0d", done_cnt, j));
    compare_value("busy_o", 32'h0, 32'(busy));
    for (int i = 0; i < len_tab[j][NUM_SOURCES]; i++) begin
      a = ADDR_W'(base_tab[j][NUM_SOURCES] + i);
      compare_value($sformatf("mem[%h]", a), z_words[j][i], mem[a]);
    end
  endtask

  task automatic finish_test(input string name, input int unsigned errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, err_cnt - errs_before);
    end
  endtask

  // Memory model, stream stimulus and stream reference model
  always @(posedge clk) begin : memory_and_streams
    logic [ADDR_W-1:0] word_addr;
    bit                hit;
    // Busy stays high from the cycle after start until done
    if (job_active && !done) compare_value("busy_o", 32'h1, 32'(busy));
    if (start) begin
      for (int k = 0; k < NUM_SOURCES; k++) rd_cnt[k] = 0;
      wr_cnt     = 0;
      z_idx      = 0;
      done_cnt   = 0;
      job_active = 1'b1;
    end
    // Read data follows one cycle after the grant seen on this edge
    mem_rvalid <= 1'b0;
    if (mem_req && mem_gnt) begin
      if (mem_we) begin
        check_true(wr_cnt < len_tab[cur_job][NUM_SOURCES],
                   $sformatf("extra write at address %h", mem_addr));
        compare_value("mem_addr_o", 32'(base_tab[cur_job][NUM_SOURCES] + ADDR_W'(wr_cnt)),
                      32'(mem_addr));
        if (wr_cnt < MAX_LEN) compare_value("mem_wdata_o", z_words[cur_job][wr_cnt], mem_wdata);
        mem[mem_addr] = mem_wdata;
        wr_cnt++;
      end else begin
        hit = 1'b0;
        for (int k = 0; k < NUM_SOURCES; k++) begin
          if (mem_addr >= base_tab[cur_job][k] &&
              32'(mem_addr) < 32'(base_tab[cur_job][k]) + len_tab[cur_job][k]) hit = 1'b1;
        end
        check_true(hit, $sformatf("read address %h lies outside every load block", mem_addr));
        mem_rvalid <= 1'b1;
        mem_rdata  <= mem[mem_addr];
      end
    end
    // Accepted load words against the memory model
    for (int k = 0; k < NUM_SOURCES; k++) begin
      if (src_valid[k] && src_ready[k]) begin
        check_true(rd_cnt[k] < len_tab[cur_job][k],
                   $sformatf("load channel %0d delivered more than %0d words", k,
                             len_tab[cur_job][k]));
        word_addr = base_tab[cur_job][k] + ADDR_W'(rd_cnt[k]);
        compare_value($sformatf("src_data_o[%0d]", k), mem[word_addr], src_data[k]);
        rd_cnt[k]++;
      end
    end
    if (done) begin
      done_cnt++;
      job_active = 1'b0;
      compare_value("busy_o", 32'h0, 32'(busy));
      for (int k = 0; k < NUM_SOURCES; k++) begin
        check_true(rd_cnt[k] == len_tab[cur_job][k],
                   $sformatf("done_o came after %0d of %0d words on load channel %0d",
                             rd_cnt[k], len_tab[cur_job][k], k));
      end
      check_true(wr_cnt == len_tab[cur_job][NUM_SOURCES],
                 $sformatf("done_o came after %0d of %0d writes", wr_cnt,
                           len_tab[cur_job][NUM_SOURCES]));
    end
    // Result stream with random gaps
    if (z_valid && z_ready) z_idx++;
    z_valid   <= job_active && (z_idx < len_tab[cur_job][NUM_SOURCES]) && (rand_below(4) != 0);
    z_data    <= (z_idx < MAX_LEN) ? z_words[cur_job][z_idx] : '0;
    src_ready <= NUM_SOURCES'($random(seed));
    mem_gnt   <= (rand_below(4) != 0);
  end

  initial begin : watchdog
    wait (limit_ns != 0);
    #(limit_ns);
    $display("timeout: the jobs did not complete within %0d ns", limit_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : sequencer
    int unsigned total;
    int unsigned errs_before;
    cfg_we    = 1'b0;
    cfg_chan  = '0;
    cfg_field = streamer_pkg::CFG_BASE;
    cfg_wdata = '0;
    start     = 1'b0;
    build_jobs();
    total = 0;
    for (int j = 0; j < NUM_JOBS; j++) begin
      for (int k = 0; k <= NUM_SOURCES; k++) total += len_tab[j][k];
    end
    limit_ns = (total * WORD_CYCLES + MARGIN_CYCLES) * PERIOD_NS;

    @(posedge rst_n);
    repeat (2) @(posedge clk);
    errs_before = err_cnt;
    compare_value("busy_o", 32'h0, 32'(busy));
    compare_value("done_o", 32'h0, 32'(done));
    compare_value("mem_req_o", 32'h0, 32'(mem_req));
    compare_value("z_ready_o", 32'h0, 32'(z_ready));
    compare_value("src_valid_o", 32'h0, 32'(src_valid));
    finish_test("reset state", errs_before);

    errs_before = err_cnt;
    run_job(0);
    finish_test("first job", errs_before);

    errs_before = err_cnt;
    run_job(1);
    finish_test("second job with an empty channel", errs_before);

    // Only the store blocks may differ from the initial image
    errs_before = err_cnt;
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (mem[a] !== ref_mem[a]) compare_value($sformatf("mem[%h]", a), ref_mem[a], mem[a]);
    end
    finish_test("memory image", errs_before);

    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, UUT.i_checker.fail_cnt);
    if (err_cnt == 0 && UUT.i_checker.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: tb_clock_gen.sv
// Testbench clock source and power-on reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial clk_o = 1'b0;
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

  // Reset held low for a fixed number of rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: streamer_checker.sv
// Protocol assertions on the streamer top level ports
// and their bind into streamer_top
`timescale 1ns/1ps

module streamer_checker #(
  parameter int unsigned NUM_SOURCES = streamer_pkg::NUM_SOURCES,
  parameter int unsigned DATA_W      = mem_pkg::DATA_W,
  parameter int unsigned ADDR_W      = mem_pkg::ADDR_W
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   mem_req_i,
  input logic                   mem_gnt_i,
  input logic                   mem_we_i,
  input logic [ADDR_W-1:0]      mem_addr_i,
  input logic [DATA_W-1:0]      mem_wdata_i,
  input logic                   busy_i,
  input logic                   done_i,
  input logic [NUM_SOURCES-1:0] src_valid_i
);

  // Failed assertions, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // Waiting request keeps every field until granted
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_we_i) && $stable(mem_addr_i)
                                && $stable(mem_wdata_i))
    else begin
      $error("memory request changed before its grant");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
    else begin
      $error("done_o held for more than one cycle");
      fail_cnt++;
    end

  // Streams only run inside a job
  valid_in_job: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !busy_i |-> src_valid_i == '0)
    else begin
      $error("src_valid_o high while busy_o is low");
      fail_cnt++;
    end

endmodule

bind streamer_top streamer_checker #(
  .NUM_SOURCES ( NUM_SOURCES ),
  .DATA_W      ( DATA_W      ),
  .ADDR_W      ( ADDR_W      )
) i_checker (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .mem_req_i   ( mem_req_o   ),
  .mem_gnt_i   ( mem_gnt_i   ),
  .mem_we_i    ( mem_we_o    ),
  .mem_addr_i  ( mem_addr_o  ),
  .mem_wdata_i ( mem_wdata_o ),
  .busy_i      ( busy_o      ),
  .done_i      ( done_o      ),
  .src_valid_i ( src_valid_o )
);

// File: streamer_top.sv
// Streamer top level: controller, load channels,
// store channel and load/store memory arbiter
`timescale 1ns/1ps

module streamer_top #(
  parameter  int unsigned NUM_SOURCES = streamer_pkg::NUM_SOURCES,
  parameter  int unsigned DATA_W      = mem_pkg::DATA_W,
  parameter  int unsigned ADDR_W      = mem_pkg::ADDR_W,
  parameter  int unsigned FIFO_DEPTH  = streamer_pkg::FIFO_DEPTH,
  localparam int unsigned CHAN_W      = $clog2(NUM_SOURCES + 1)
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               cfg_we_i,
  input  logic [CHAN_W-1:0]                  cfg_chan_i,
  input  streamer_pkg::cfg_field_e           cfg_field_i,
  input  logic [ADDR_W-1:0]                  cfg_wdata_i,
  input  logic                               start_i,
  input  logic [NUM_SOURCES-1:0]             src_ready_i,
  input  logic                               z_valid_i,
  input  logic [DATA_W-1:0]                  z_data_i,
  input  logic                               mem_gnt_i,
  input  logic                               mem_rvalid_i,
  input  logic [DATA_W-1:0]                  mem_rdata_i,
  output logic                               busy_o,
  output logic                               done_o,
  output logic [NUM_SOURCES-1:0]             src_valid_o,
  output logic [NUM_SOURCES-1:0][DATA_W-1:0] src_data_o,
  output logic                               z_ready_o,
  output logic                               mem_req_o,
  output logic                               mem_we_o,
  output logic [ADDR_W-1:0]                  mem_addr_o,
  output logic [DATA_W-1:0]                  mem_wdata_o
);

  logic                                          job_start;
  logic [NUM_SOURCES:0][ADDR_W-1:0]              job_base;
  logic [NUM_SOURCES:0][streamer_pkg::LEN_W-1:0] job_len;
  // Busy flags, store channel on the top bit
  logic [NUM_SOURCES:0]                          chan_busy;
  logic [NUM_SOURCES-1:0]                        ld_req;
  logic [NUM_SOURCES-1:0][ADDR_W-1:0]            ld_addr;
  logic [NUM_SOURCES-1:0]                        ld_gnt;
  logic [NUM_SOURCES-1:0]                        ld_rvalid;
  logic [DATA_W-1:0]                             ld_rdata;
  logic                                          st_req;
  logic [ADDR_W-1:0]                             st_addr;
  logic [DATA_W-1:0]                             st_wdata;
  logic                                          st_gnt;

  streamer_ctrl #(
    .NUM_SOURCES ( NUM_SOURCES ),
    .ADDR_W      ( ADDR_W      )
  ) i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_chan_i  ( cfg_chan_i  ),
    .cfg_field_i ( cfg_field_i ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .start_i     ( start_i     ),
    .chan_busy_i ( chan_busy   ),
    .job_start_o ( job_start   ),
    .job_base_o  ( job_base    ),
    .job_len_o   ( job_len     ),
    .busy_o      ( busy_o      ),
    .done_o      ( done_o      )
  );

  // One load channel per source stream
  for (genvar i = 0; i < NUM_SOURCES; i++) begin : gen_source
    stream_source #(
      .DATA_W      ( DATA_W         ),
      .ADDR_W      ( ADDR_W         ),
      .FIFO_DEPTH  ( FIFO_DEPTH     )
    ) i_source (
      .clk_i       ( clk_i          ),
      .rst_n_i     ( rst_n_i        ),
      .job_start_i ( job_start      ),
      .base_i      ( job_base[i]    ),
      .len_i       ( job_len[i]     ),
      .gnt_i       ( ld_gnt[i]      ),
      .rvalid_i    ( ld_rvalid[i]   ),
      .rdata_i     ( ld_rdata       ),
      .src_ready_i ( src_ready_i[i] ),
      .req_o       ( ld_req[i]      ),
      .addr_o      ( ld_addr[i]     ),
      .busy_o      ( chan_busy[i]   ),
      .src_valid_o ( src_valid_o[i] ),
      .src_data_o  ( src_data_o[i]  )
    );
  end

  stream_sink #(
    .DATA_W      ( DATA_W                 ),
    .ADDR_W      ( ADDR_W                 )
  ) i_sink (
    .clk_i       ( clk_i                  ),
    .rst_n_i     ( rst_n_i                ),
    .job_start_i ( job_start              ),
    .base_i      ( job_base[NUM_SOURCES]  ),
    .len_i       ( job_len[NUM_SOURCES]   ),
    .z_valid_i   ( z_valid_i              ),
    .z_data_i    ( z_data_i               ),
    .gnt_i       ( st_gnt                 ),
    .z_ready_o   ( z_ready_o              ),
    .req_o       ( st_req                 ),
    .addr_o      ( st_addr                ),
    .wdata_o     ( st_wdata               ),
    .busy_o      ( chan_busy[NUM_SOURCES] )
  );

  mem_ldst_arbiter #(
    .NUM_SOURCES  ( NUM_SOURCES  ),
    .DATA_W       ( DATA_W       ),
    .ADDR_W       ( ADDR_W       )
  ) i_arbiter (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .ld_req_i     ( ld_req       ),
    .ld_addr_i    ( ld_addr      ),
    .st_req_i     ( st_req       ),
    .st_addr_i    ( st_addr      ),
    .st_wdata_i   ( st_wdata     ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  ),
    .ld_gnt_o     ( ld_gnt       ),
    .ld_rvalid_o  ( ld_rvalid    ),
    .ld_rdata_o   ( ld_rdata     ),
    .st_gnt_o     ( st_gnt       ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  )
  );

endmodule

// File: mem_ldst_arbiter.sv
// Load/store arbiter onto one req/gnt memory port:
// store first, round-robin loads, read response routing
`timescale 1ns/1ps

module mem_ldst_arbiter #(
  parameter  int unsigned NUM_SOURCES = streamer_pkg::NUM_SOURCES,
  parameter  int unsigned DATA_W      = mem_pkg::DATA_W,
  parameter  int unsigned ADDR_W      = mem_pkg::ADDR_W,
  localparam int unsigned IDX_W       = (NUM_SOURCES > 1) ? $clog2(NUM_SOURCES) : 1
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [NUM_SOURCES-1:0]              ld_req_i,
  input  logic [NUM_SOURCES-1:0][ADDR_W-1:0]  ld_addr_i,
  input  logic                                st_req_i,
  input  logic [ADDR_W-1:0]                   st_addr_i,
  input  logic [DATA_W-1:0]                   st_wdata_i,
  input  logic                                mem_gnt_i,
  input  logic                                mem_rvalid_i,
  input  logic [DATA_W-1:0]                   mem_rdata_i,
  output logic [NUM_SOURCES-1:0]              ld_gnt_o,
  output logic [NUM_SOURCES-1:0]              ld_rvalid_o,
  output logic [DATA_W-1:0]                   ld_rdata_o,
  output logic                                st_gnt_o,
  output logic                                mem_req_o,
  output logic                                mem_we_o,
  output logic [ADDR_W-1:0]                   mem_addr_o,
  output logic [DATA_W-1:0]                   mem_wdata_o
);

  logic [IDX_W-1:0]  rr_q;
  logic [IDX_W-1:0]  rr_idx;
  logic              rr_any;
  logic [IDX_W-1:0]  sel_idx;
  logic              sel_store;
  logic              sel_load;
  logic              hold_q;
  logic              hold_store_q;
  logic [IDX_W-1:0]  hold_idx_q;
  logic              rd_pend_q;
  logic [IDX_W-1:0]  rd_idx_q;
  mem_pkg::mem_op_e  op;

  // Round-robin search begins after the last granted load
  always_comb begin : rr_search
    int unsigned cand;
    rr_idx = '0;
    rr_any = 1'b0;
    for (int unsigned k = 1; k <= NUM_SOURCES; k++) begin
      cand = (int'(rr_q) + k) % NUM_SOURCES;
      if (!rr_any && ld_req_i[cand]) begin
        rr_any = 1'b1;
        rr_idx = IDX_W'(cand);
      end
    end
  end

  // An ungranted request stays on the port, a new store waits behind it
  always_comb begin
    if (hold_q) begin
      sel_store = hold_store_q;
      sel_load  = !hold_store_q;
      sel_idx   = hold_idx_q;
    end else begin
      sel_store = st_req_i;
      sel_load  = !st_req_i && rr_any;
      sel_idx   = rr_idx;
    end
  end

  assign op          = sel_store ? mem_pkg::MEM_WRITE : mem_pkg::MEM_READ;
  assign mem_req_o   = sel_store || sel_load;
  assign mem_we_o    = (op == mem_pkg::MEM_WRITE);
  assign mem_addr_o  = sel_store ? st_addr_i : ld_addr_i[sel_idx];
  // Write data only on writes, keeps a waiting read request steady
  assign mem_wdata_o = sel_store ? st_wdata_i : '0;

  assign st_gnt_o = mem_gnt_i && sel_store;
  assign ld_gnt_o = (mem_gnt_i && sel_load) ? (NUM_SOURCES'(1) << sel_idx) : '0;

  // Response is one cycle after the grant, only the owner sees rvalid
  assign ld_rvalid_o = (mem_rvalid_i && rd_pend_q) ? (NUM_SOURCES'(1) << rd_idx_q) : '0;
  assign ld_rdata_o  = mem_rdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q         <= IDX_W'(NUM_SOURCES - 1);
      hold_q       <= 1'b0;
      hold_store_q <= 1'b0;
      hold_idx_q   <= '0;
      rd_pend_q    <= 1'b0;
      rd_idx_q     <= '0;
    end else begin
      hold_q       <= mem_req_o && !mem_gnt_i;
      hold_store_q <= sel_store;
      hold_idx_q   <= sel_idx;
      rd_pend_q    <= mem_req_o && mem_gnt_i && (op == mem_pkg::MEM_READ);
      rd_idx_q     <= sel_idx;
      if (mem_gnt_i && sel_load) rr_q <= sel_idx;
    end
  end

endmodule

// File: stream_sink.sv
// Store channel: captures one result word at a time
// and issues its write to the next block address
`timescale 1ns/1ps

module stream_sink #(
  parameter int unsigned DATA_W = mem_pkg::DATA_W,
  parameter int unsigned ADDR_W = mem_pkg::ADDR_W
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           job_start_i,
  input  logic [ADDR_W-1:0]              base_i,
  input  logic [streamer_pkg::LEN_W-1:0] len_i,
  input  logic                           z_valid_i,
  input  logic [DATA_W-1:0]              z_data_i,
  input  logic                           gnt_i,
  output logic                           z_ready_o,
  output logic                           req_o,
  output logic [ADDR_W-1:0]              addr_o,
  output logic [DATA_W-1:0]              wdata_o,
  output logic                           busy_o
);

  logic                           busy_q;
  logic                           full_q;
  logic [streamer_pkg::LEN_W-1:0] left_q;
  logic [ADDR_W-1:0]              addr_q;
  logic [DATA_W-1:0]              wdata_q;
  logic                           capture;
  logic                           written;

  // Held word blocks the result stream until written
  assign z_ready_o = busy_q && !full_q;
  assign capture   = z_valid_i && z_ready_o;
  assign req_o     = full_q;
  assign written   = full_q && gnt_i;
  assign addr_o    = addr_q;
  assign wdata_o   = wdata_q;
  assign busy_o    = busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      full_q <= 1'b0;
      left_q <= '0;
    end else if (job_start_i) begin
      busy_q <= (len_i != '0);
      full_q <= 1'b0;
      left_q <= len_i;
    end else if (written) begin
      full_q <= 1'b0;
      left_q <= left_q - 1'b1;
      // Last grant closes the job
      if (left_q == 1) busy_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (job_start_i) addr_q <= base_i;
    else if (written) addr_q <= addr_q + 1'b1;
    if (capture) wdata_q <= z_data_i;
  end

endmodule

// File: stream_source.sv
// Load channel: linear read address generator, credit counter
// bounding outstanding words, and output FIFO feeding a valid/ready stream
`timescale 1ns/1ps

module stream_source #(
  parameter int unsigned DATA_W     = mem_pkg::DATA_W,
  parameter int unsigned ADDR_W     = mem_pkg::ADDR_W,
  parameter int unsigned FIFO_DEPTH = streamer_pkg::FIFO_DEPTH
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           job_start_i,
  input  logic [ADDR_W-1:0]              base_i,
  input  logic [streamer_pkg::LEN_W-1:0] len_i,
  input  logic                           gnt_i,
  input  logic                           rvalid_i,
  input  logic [DATA_W-1:0]              rdata_i,
  input  logic                           src_ready_i,
  output logic                           req_o,
  output logic [ADDR_W-1:0]              addr_o,
  output logic                           busy_o,
  output logic                           src_valid_o,
  output logic [DATA_W-1:0]              src_data_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic                           busy_q;
  logic [ADDR_W-1:0]              addr_q;
  logic [streamer_pkg::LEN_W-1:0] req_left_q;
  logic [streamer_pkg::LEN_W-1:0] out_left_q;
  logic [CNT_W-1:0]               credit_q;
  logic [CNT_W-1:0]               fill_q;
  logic [PTR_W-1:0]               wr_ptr_q;
  logic [PTR_W-1:0]               rd_ptr_q;
  logic [DATA_W-1:0]              fifo_q [FIFO_DEPTH];
  logic                           issue;
  logic                           pop;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  // Credits count words in flight plus words buffered,
  // capped at the FIFO depth so a response always has room
  assign req_o       = busy_q && (req_left_q != '0) && (credit_q < CNT_W'(FIFO_DEPTH));
  assign issue       = req_o && gnt_i;
  assign src_valid_o = (fill_q != '0);
  assign src_data_o  = fifo_q[rd_ptr_q];
  assign pop         = src_valid_o && src_ready_i;
  assign addr_o      = addr_q;
  assign busy_o      = busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      addr_q     <= '0;
      req_left_q <= '0;
      out_left_q <= '0;
      credit_q   <= '0;
      fill_q     <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
    end else begin
      if (job_start_i) begin
        // Zero length finishes at once
        busy_q     <= (len_i != '0);
        addr_q     <= base_i;
        req_left_q <= len_i;
        out_left_q <= len_i;
      end else begin
        if (issue) begin
          addr_q     <= addr_q + 1'b1;
          req_left_q <= req_left_q - 1'b1;
        end
        // Job ends when the last word leaves the FIFO
        if (pop) begin
          out_left_q <= out_left_q - 1'b1;
          if (out_left_q == 1) busy_q <= 1'b0;
        end
      end
      case ({issue, pop})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
      case ({rvalid_i, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      if (rvalid_i) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
    end
  end

  // Response word is visible on the stream the next cycle
  always_ff @(posedge clk_i) begin
    if (rvalid_i) fifo_q[wr_ptr_q] <= rdata_i;
  end

endmodule

// File: streamer_ctrl.sv
// Streamer controller with per-channel base and length registers,
// job start fan-out and completion detection
`timescale 1ns/1ps

module streamer_ctrl #(
  parameter  int unsigned NUM_SOURCES = streamer_pkg::NUM_SOURCES,
  parameter  int unsigned ADDR_W      = mem_pkg::ADDR_W,
  localparam int unsigned CHAN_W      = $clog2(NUM_SOURCES + 1)
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                                          cfg_we_i,
  input  logic [CHAN_W-1:0]                             cfg_chan_i,
  input  streamer_pkg::cfg_field_e                      cfg_field_i,
  input  logic [ADDR_W-1:0]                             cfg_wdata_i,
  input  logic                                          start_i,
  input  logic [NUM_SOURCES:0]                          chan_busy_i,
  output logic                                          job_start_o,
  output logic [NUM_SOURCES:0][ADDR_W-1:0]              job_base_o,
  output logic [NUM_SOURCES:0][streamer_pkg::LEN_W-1:0] job_len_o,
  output logic                                          busy_o,
  output logic                                          done_o
);

  streamer_pkg::ctrl_state_e                    state_q;
  streamer_pkg::ctrl_state_e                    state_d;
  logic                                         job_start_q;
  logic [NUM_SOURCES:0][ADDR_W-1:0]             base_q;
  logic [NUM_SOURCES:0][streamer_pkg::LEN_W-1:0] len_q;

  // Index NUM_SOURCES addresses the store channel
  always_ff @(posedge clk_i) begin
    if (cfg_we_i && state_q == streamer_pkg::IDLE && int'(cfg_chan_i) <= NUM_SOURCES) begin
      case (cfg_field_i)
        streamer_pkg::CFG_BASE: base_q[cfg_chan_i] <= cfg_wdata_i;
        default:                len_q[cfg_chan_i]  <= cfg_wdata_i[streamer_pkg::LEN_W-1:0];
      endcase
    end
  end

  // Channels raise busy one cycle after job start,
  // so RUN ignores the flags during the start pulse
  always_comb begin
    state_d = state_q;
    case (state_q)
      streamer_pkg::IDLE: begin
        if (start_i) state_d = streamer_pkg::RUN;
      end
      streamer_pkg::RUN: begin
        if (!job_start_q && chan_busy_i == '0) state_d = streamer_pkg::FINISH;
      end
      default: state_d = streamer_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= streamer_pkg::IDLE;
      job_start_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      job_start_q <= (state_q == streamer_pkg::IDLE) && start_i;
    end
  end

  assign job_start_o = job_start_q;
  assign job_base_o  = base_q;
  assign job_len_o   = len_q;
  // Busy drops in the same cycle that done pulses
  assign busy_o      = (state_q == streamer_pkg::RUN);
  assign done_o      = (state_q == streamer_pkg::FINISH);

endmodule

// File: streamer_pkg.sv
// Streamer defaults for channel count, FIFO depth and block length
// Controller states and configuration field selectors
package streamer_pkg;

  // Load channels X, W and Y
  localparam int unsigned NUM_SOURCES = 3;

  // Words held per load channel output FIFO
  localparam int unsigned FIFO_DEPTH = 2;

  // Block length width in words
  localparam int unsigned LEN_W = 8;

  // Register hit by a configuration write
  typedef enum logic {
    CFG_BASE = 1'b0,
    CFG_LEN  = 1'b1
  } cfg_field_e;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    RUN    = 2'd1,
    FINISH = 2'd2
  } ctrl_state_e;

endpackage

// File: mem_pkg.sv
// Memory port word and address widths
// Encoding of the memory request operation
package mem_pkg;

  // Word width of the memory port and of every stream
  localparam int unsigned DATA_W = 32;

  // Word address width
  localparam int unsigned ADDR_W = 16;

  // Operation carried by a memory request
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

endpackage
